// File: alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// operand and result width
`define ALU_WORD_W 32

// shift amounts and field positions
`define ALU_SHAMT_W 5

// opcode field of a request
`define ALU_OP_W 5

// leading/trailing count, 0 to 32
`define ALU_CNT_W 6

`endif

// File: alu_data_pkg.sv
`default_nettype none

`include "alu_config.svh"

package alu_data_pkg;

  typedef logic [`ALU_WORD_W-1:0] alu_word_t;
  typedef logic [`ALU_SHAMT_W-1:0] alu_shamt_t;
  typedef logic [`ALU_CNT_W-1:0] alu_cnt_t;

  // ext/ins view of the immediate
  typedef struct packed {
    logic [`ALU_WORD_W-2*`ALU_SHAMT_W-2:0] rsvd_hi;
    alu_shamt_t                            msbw;
    logic                                  rsvd_mid;
    alu_shamt_t                            lsbw;
  } field_view_t;

  // lsa and count view, bit 0 also selects count polarity
  typedef struct packed {
    logic [`ALU_WORD_W-3:0] rsvd;
    logic [1:0]             sa;
  } aux_view_t;

  typedef union packed {
    field_view_t field;
    aux_view_t   aux;
  } alu_imm_u;

endpackage

`default_nettype wire

// File: alu_op_pkg.sv
`default_nettype none

`include "alu_config.svh"

package alu_op_pkg;

  import alu_data_pkg::*;

  // codes above op_seh are unassigned
  typedef enum logic [`ALU_OP_W-1:0] {
    op_add, op_sub, op_slt, op_sltu, op_lsa,
    op_and, op_or, op_xor, op_nor, op_andn, op_orn,
    op_sll, op_srl, op_sra, op_rotr, op_ext, op_ins,
    op_clo_lead, op_clo_tail, op_bitrev, op_revb, op_seb, op_seh
  } alu_op_e;

  typedef struct packed {
    alu_op_e   op;
    alu_word_t a;
    alu_word_t b;
    alu_imm_u  c;
  } alu_req_t;

  typedef enum logic [1:0] {
    unit_none, unit_adder, unit_shift_field, unit_bitwise
  } alu_unit_e;

  typedef enum logic [2:0] {
    add_add, add_sub, add_slt, add_sltu, add_lsa
  } add_mode_e;

  typedef enum logic [2:0] {
    sh_sll, sh_srl, sh_sra, sh_rotr, sh_ext, sh_ins
  } shift_mode_e;

  typedef enum logic [3:0] {
    bit_and, bit_or, bit_xor, bit_nor, bit_andn, bit_orn,
    bit_clo_lead, bit_clo_tail, bit_bitrev, bit_revb, bit_seb, bit_seh
  } bit_mode_e;

  typedef struct packed {
    alu_unit_e   unit;
    add_mode_e   add_mode;
    shift_mode_e shift_mode;
    bit_mode_e   bit_mode;
  } alu_ctrl_t;

endpackage

`default_nettype wire

// File: lead_counter.sv
`default_nettype none

module lead_counter #(
  parameter int WIDTH = 32
) (
  input  wire [WIDTH-1:0]        bits,
  output logic [$clog2(WIDTH):0] count
);

  localparam int HALF = WIDTH / 2;

  generate
    if (WIDTH == 4) begin : g_leaf
      always_comb begin
        casez (bits)
          4'b1111: count = 3'd4;
          4'b1110: count = 3'd3;
          4'b110?: count = 3'd2;
          4'b10??: count = 3'd1;
          default: count = 3'd0;
        endcase
      end
    end else begin : g_split
      logic [$clog2(HALF):0] hi_cnt;
      logic [$clog2(HALF):0] lo_cnt;

      lead_counter #(.WIDTH(HALF)) hi_inst (
        .bits  (bits[WIDTH-1:HALF]),
        .count (hi_cnt)
      );

      lead_counter #(.WIDTH(HALF)) lo_inst (
        .bits  (bits[HALF-1:0]),
        .count (lo_cnt)
      );

      // msb of hi_cnt set means the high half is all ones
      assign count = hi_cnt[$clog2(HALF)] ? ({1'b0, hi_cnt} + {1'b0, lo_cnt})
                                          : {1'b0, hi_cnt};
    end
  endgenerate

endmodule

`default_nettype wire

// File: alu_decoder.sv
`default_nettype none

module alu_decoder
  import alu_op_pkg::*;
(
  input  wire alu_op_e op,
  output alu_ctrl_t    ctrl
);

  always_comb begin
    case (op)
      op_add, op_sub, op_slt, op_sltu, op_lsa:
        ctrl.unit = unit_adder;
      op_sll, op_srl, op_sra, op_rotr, op_ext, op_ins:
        ctrl.unit = unit_shift_field;
      op_and, op_or, op_xor, op_nor, op_andn, op_orn,
      op_clo_lead, op_clo_tail, op_bitrev, op_revb, op_seb, op_seh:
        ctrl.unit = unit_bitwise;
      default:
        ctrl.unit = unit_none;
    endcase

    case (op)
      op_sub:  ctrl.add_mode = add_sub;
      op_slt:  ctrl.add_mode = add_slt;
      op_sltu: ctrl.add_mode = add_sltu;
      op_lsa:  ctrl.add_mode = add_lsa;
      default: ctrl.add_mode = add_add;
    endcase

    case (op)
      op_srl:  ctrl.shift_mode = sh_srl;
      op_sra:  ctrl.shift_mode = sh_sra;
      op_rotr: ctrl.shift_mode = sh_rotr;
      op_ext:  ctrl.shift_mode = sh_ext;
      op_ins:  ctrl.shift_mode = sh_ins;
      default: ctrl.shift_mode = sh_sll;
    endcase

    case (op)
      op_or:       ctrl.bit_mode = bit_or;
      op_xor:      ctrl.bit_mode = bit_xor;
      op_nor:      ctrl.bit_mode = bit_nor;
      op_andn:     ctrl.bit_mode = bit_andn;
      op_orn:      ctrl.bit_mode = bit_orn;
      op_clo_lead: ctrl.bit_mode = bit_clo_lead;
      op_clo_tail: ctrl.bit_mode = bit_clo_tail;
      op_bitrev:   ctrl.bit_mode = bit_bitrev;
      op_revb:     ctrl.bit_mode = bit_revb;
      op_seb:      ctrl.bit_mode = bit_seb;
      op_seh:      ctrl.bit_mode = bit_seh;
      default:     ctrl.bit_mode = bit_and;
    endcase
  end

  // every assigned opcode must reach some unit
  always_comb begin
    assert final ($isunknown(op) || op > op_seh || ctrl.unit != unit_none)
      else $error("opcode %0d decoded to no unit", op);
  end

endmodule

`default_nettype wire

// File: alu_adder.sv
`default_nettype none

`include "alu_config.svh"

module alu_adder
  import alu_data_pkg::*;
  import alu_op_pkg::*;
(
  input  wire add_mode_e mode,
  input  wire alu_word_t a,
  input  wire alu_word_t b,
  input  wire alu_imm_u  c,
  output alu_word_t      sum
);

  logic      inv_b;
  logic [2:0] lsa_sh;
  alu_word_t a_in;
  alu_word_t b_in;
  alu_word_t raw;
  logic      carry;
  logic      ovf;
  logic      signed_lt;
  logic      unsigned_lt;

  // subtract style ops add ~b plus one
  assign inv_b = (mode == add_sub) || (mode == add_slt) || (mode == add_sltu);
  assign lsa_sh = {1'b0, c.aux.sa} + 3'd1;
  assign a_in = (mode == add_lsa) ? (a << lsa_sh) : a;
  assign b_in = inv_b ? ~b : b;

  assign {carry, raw} = {1'b0, a_in} + {1'b0, b_in} + {{`ALU_WORD_W{1'b0}}, inv_b};

  // carry into msb differs from carry out
  assign ovf = a_in[`ALU_WORD_W-1] ^ b_in[`ALU_WORD_W-1] ^ raw[`ALU_WORD_W-1] ^ carry;
  assign signed_lt = raw[`ALU_WORD_W-1] ^ ovf;
  assign unsigned_lt = !carry;

  always_comb begin
    case (mode)
      add_slt:  sum = {{(`ALU_WORD_W-1){1'b0}}, signed_lt};
      add_sltu: sum = {{(`ALU_WORD_W-1){1'b0}}, unsigned_lt};
      default:  sum = raw;
    endcase
  end

endmodule

`default_nettype wire

// File: alu_shift_field.sv
`default_nettype none

`include "alu_config.svh"

module alu_shift_field
  import alu_data_pkg::*;
  import alu_op_pkg::*;
(
  input  wire shift_mode_e mode,
  input  wire alu_word_t   a,
  input  wire alu_word_t   b,
  input  wire alu_imm_u    c,
  output alu_word_t        shifted
);

  alu_shamt_t               rot_amt;
  logic [2*`ALU_WORD_W-1:0] rot_wide;
  logic [2*`ALU_WORD_W-1:0] sr_wide;
  alu_word_t                rotated;
  alu_word_t                ext_mask;
  alu_word_t                ins_mask;
  logic [`ALU_SHAMT_W:0]    ext_len;
  logic [`ALU_SHAMT_W:0]    ins_top;
  logic                     sign_fill;

  // ext rotates the field down to bit 0
  assign rot_amt = (mode == sh_ext) ? c.field.lsbw : b[`ALU_SHAMT_W-1:0];
  assign rot_wide = {a, a} >> rot_amt;
  assign rotated = rot_wide[`ALU_WORD_W-1:0];

  // field length 1..32, a shift by 32 clears the word
  assign ext_len = {1'b0, c.field.msbw} - {1'b0, c.field.lsbw}
                   + {{`ALU_SHAMT_W{1'b0}}, 1'b1};
  assign ext_mask = ~({`ALU_WORD_W{1'b1}} << ext_len);

  assign ins_top = {1'b0, c.field.msbw} + {{`ALU_SHAMT_W{1'b0}}, 1'b1};
  assign ins_mask = ({`ALU_WORD_W{1'b1}} << c.field.lsbw)
                    & ~({`ALU_WORD_W{1'b1}} << ins_top);

  // srl and sra share one shifter
  assign sign_fill = (mode == sh_sra) && a[`ALU_WORD_W-1];
  assign sr_wide = {{`ALU_WORD_W{sign_fill}}, a} >> b[`ALU_SHAMT_W-1:0];

  always_comb begin
    case (mode)
      sh_sll:  shifted = a << b[`ALU_SHAMT_W-1:0];
      sh_srl,
      sh_sra:  shifted = sr_wide[`ALU_WORD_W-1:0];
      sh_rotr: shifted = rotated;
      sh_ext:  shifted = rotated & ext_mask;
      sh_ins:  shifted = (b & ~ins_mask) | ((a << c.field.lsbw) & ins_mask);
      default: shifted = '0;
    endcase
  end

  // field ops need an ordered bit range
  always_comb begin
    assert final ($isunknown(mode) || !(mode == sh_ext || mode == sh_ins)
                  || c.field.msbw >= c.field.lsbw)
      else $error("field op with msbw %0d below lsbw %0d", c.field.msbw, c.field.lsbw);
  end

endmodule

`default_nettype wire

// File: alu_bitwise_unit.sv
`default_nettype none

`include "alu_config.svh"

module alu_bitwise_unit
  import alu_data_pkg::*;
  import alu_op_pkg::*;
(
  input  wire bit_mode_e mode,
  input  wire alu_word_t a,
  input  wire alu_word_t b,
  input  wire alu_imm_u  c,
  output alu_word_t      bits_out
);

  alu_word_t rev_a;
  alu_word_t cnt_src;
  alu_word_t cnt_in;
  alu_cnt_t  lead_cnt;
  logic      count_ones;

  always_comb begin
    for (int i = 0; i < `ALU_WORD_W; i++) begin
      rev_a[i] = a[`ALU_WORD_W-1-i];
    end
  end

  // trailing count is a leading count of the reversed word
  assign count_ones = c.aux.sa[0];
  assign cnt_src = (mode == bit_clo_tail) ? rev_a : a;
  assign cnt_in = count_ones ? cnt_src : ~cnt_src;

  lead_counter #(.WIDTH(`ALU_WORD_W)) lead_counter_inst (
    .bits  (cnt_in),
    .count (lead_cnt)
  );

  always_comb begin
    case (mode)
      bit_and:      bits_out = a & b;
      bit_or:       bits_out = a | b;
      bit_xor:      bits_out = a ^ b;
      bit_nor:      bits_out = ~(a | b);
      bit_andn:     bits_out = a & ~b;
      bit_orn:      bits_out = a | ~b;
      bit_clo_lead,
      bit_clo_tail: bits_out = {{(`ALU_WORD_W-`ALU_CNT_W){1'b0}}, lead_cnt};
      bit_bitrev:   bits_out = rev_a;
      bit_revb:     bits_out = {a[7:0], a[15:8], a[23:16], a[31:24]};
      bit_seb:      bits_out = {{24{a[7]}}, a[7:0]};
      bit_seh:      bits_out = {{16{a[15]}}, a[15:0]};
      default:      bits_out = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: alu_exec_stage.sv
`default_nettype none

module alu_exec_stage
  import alu_data_pkg::*;
  import alu_op_pkg::*;
(
  input  wire           clk,
  input  wire           rst_n,
  input  wire           req_valid,
  input  wire alu_req_t req,
  output logic          res_valid,
  output alu_word_t     res
);

  alu_ctrl_t ctrl;
  alu_word_t add_out;
  alu_word_t shift_out;
  alu_word_t bit_out;
  alu_word_t res_next;

  alu_decoder alu_decoder_inst (
    .op   (req.op),
    .ctrl (ctrl)
  );

  alu_adder alu_adder_inst (
    .mode (ctrl.add_mode),
    .a    (req.a),
    .b    (req.b),
    .c    (req.c),
    .sum  (add_out)
  );

  alu_shift_field alu_shift_field_inst (
    .mode    (ctrl.shift_mode),
    .a       (req.a),
    .b       (req.b),
    .c       (req.c),
    .shifted (shift_out)
  );

  alu_bitwise_unit alu_bitwise_unit_inst (
    .mode     (ctrl.bit_mode),
    .a        (req.a),
    .b        (req.b),
    .c        (req.c),
    .bits_out (bit_out)
  );

  // unassigned opcodes give zero
  always_comb begin
    case (ctrl.unit)
      unit_adder:       res_next = add_out;
      unit_shift_field: res_next = shift_out;
      unit_bitwise:     res_next = bit_out;
      default:          res_next = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
      res <= '0;
    end else begin
      res_valid <= req_valid;
      if (req_valid) begin
        res <= res_next;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(res_valid))
    else $error("res_valid unknown");

endmodule

`default_nettype wire

// File: tb_alu_exec_stage.sv
`default_nettype none

module tb_alu_exec_stage
  import alu_data_pkg::*;
  import alu_op_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20;
  localparam int STREAM_LEN = 200;

  typedef struct packed {
    alu_op_e   op;
    alu_word_t a;
    alu_word_t b;
    alu_word_t c;
    alu_word_t expected;
  } row_t;

  logic      clk;
  logic      rst_n;
  logic      req_valid;
  alu_req_t  req;
  logic      res_valid;
  alu_word_t res;

  row_t      rows[$];
  alu_word_t stream_exp[$];
  int        test_cnt;
  int        pass_cnt;
  int        fail_cnt;

  alu_exec_stage alu_exec_stage_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .res_valid (res_valid),
    .res       (res)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // msbw at 10:6, lsbw at 4:0
  function automatic alu_word_t field_imm(input int msbw, input int lsbw);
    alu_word_t w;
    w = '0;
    w[10:6] = msbw[4:0];
    w[4:0] = lsbw[4:0];
    return w;
  endfunction

  function automatic void add_row(input alu_op_e op, input alu_word_t a, input alu_word_t b,
                                  input alu_word_t c, input alu_word_t expected);
    row_t r;
    r.op = op;
    r.a = a;
    r.b = b;
    r.c = c;
    r.expected = expected;
    rows.push_back(r);
  endfunction

  function automatic void load_rows();
    add_row(op_add, 32'h7fffffff, 32'h80000000, 32'h0, 32'hffffffff);
    add_row(op_add, 32'hffffffff, 32'h00000001, 32'h0, 32'h00000000);
    add_row(op_sub, 32'h7fffffff, 32'h80000000, 32'h0, 32'hffffffff);
    add_row(op_sub, 32'hffffffff, 32'h00000001, 32'h0, 32'hfffffffe);
    add_row(op_slt, 32'h7fffffff, 32'h80000000, 32'h0, 32'h00000000);
    add_row(op_slt, 32'hffffffff, 32'h00000001, 32'h0, 32'h00000001);
    add_row(op_sltu, 32'h7fffffff, 32'h80000000, 32'h0, 32'h00000001);
    add_row(op_sltu, 32'hffffffff, 32'h00000001, 32'h0, 32'h00000000);
    // lsa with sa 0..3
    add_row(op_lsa, 32'h3, 32'h5, 32'h0, 32'h0000000b);
    add_row(op_lsa, 32'h3, 32'h5, 32'h1, 32'h00000011);
    add_row(op_lsa, 32'h3, 32'h5, 32'h2, 32'h0000001d);
    add_row(op_lsa, 32'h3, 32'h5, 32'h3, 32'h00000035);
    add_row(op_and, 32'hff00ff00, 32'hf0f0f0f0, 32'h0, 32'hf000f000);
    add_row(op_or, 32'hff00ff00, 32'hf0f0f0f0, 32'h0, 32'hfff0fff0);
    add_row(op_xor, 32'hff00ff00, 32'hf0f0f0f0, 32'h0, 32'h0ff00ff0);
    add_row(op_nor, 32'hff00ff00, 32'hf0f0f0f0, 32'h0, 32'h000f000f);
    add_row(op_andn, 32'hff00ff00, 32'hf0f0f0f0, 32'h0, 32'h0f000f00);
    add_row(op_orn, 32'hff00ff00, 32'hf0f0f0f0, 32'h0, 32'hff0fff0f);
    add_row(op_sll, 32'h80000001, 32'd0, 32'h0, 32'h80000001);
    add_row(op_sll, 32'h80000001, 32'd1, 32'h0, 32'h00000002);
    add_row(op_sll, 32'h80000001, 32'd31, 32'h0, 32'h80000000);
    add_row(op_srl, 32'h80000001, 32'd0, 32'h0, 32'h80000001);
    add_row(op_srl, 32'h80000001, 32'd1, 32'h0, 32'h40000000);
    add_row(op_srl, 32'h80000001, 32'd31, 32'h0, 32'h00000001);
    add_row(op_sra, 32'h80000001, 32'd0, 32'h0, 32'h80000001);
    add_row(op_sra, 32'h80000001, 32'd1, 32'h0, 32'hc0000000);
    add_row(op_sra, 32'h80000001, 32'd31, 32'h0, 32'hffffffff);
    add_row(op_rotr, 32'h80000001, 32'd0, 32'h0, 32'h80000001);
    add_row(op_rotr, 32'h80000001, 32'd1, 32'h0, 32'hc0000000);
    add_row(op_rotr, 32'h80000001, 32'd31, 32'h0, 32'h00000003);
    add_row(op_ext, 32'h12345678, 32'h0, field_imm(31, 0), 32'h12345678);
    add_row(op_ext, 32'h12345678, 32'h0, field_imm(15, 8), 32'h00000056);
    add_row(op_ext, 32'h12345678, 32'h0, field_imm(7, 4), 32'h00000007);
    add_row(op_ext, 32'h12345678, 32'h0, field_imm(3, 3), 32'h00000001);
    add_row(op_ins, 32'h12345678, 32'hffffffff, field_imm(31, 0), 32'h12345678);
    add_row(op_ins, 32'h000000ab, 32'h11223344, field_imm(15, 8), 32'h1122ab44);
    add_row(op_ins, 32'h00000000, 32'hffffffff, field_imm(5, 5), 32'hffffffdf);
    // c bit 0 picks ones or zeros
    add_row(op_clo_lead, 32'h00000000, 32'h0, 32'h0, 32'h00000020);
    add_row(op_clo_lead, 32'h00000000, 32'h0, 32'h1, 32'h00000000);
    add_row(op_clo_lead, 32'hffffffff, 32'h0, 32'h1, 32'h00000020);
    add_row(op_clo_lead, 32'hffffffff, 32'h0, 32'h0, 32'h00000000);
    add_row(op_clo_tail, 32'h00000000, 32'h0, 32'h0, 32'h00000020);
    add_row(op_clo_tail, 32'h00000000, 32'h0, 32'h1, 32'h00000000);
    add_row(op_clo_tail, 32'hffffffff, 32'h0, 32'h1, 32'h00000020);
    add_row(op_clo_tail, 32'hffffffff, 32'h0, 32'h0, 32'h00000000);
    add_row(op_clo_lead, 32'h00010000, 32'h0, 32'h0, 32'h0000000f);
    add_row(op_clo_tail, 32'h00010000, 32'h0, 32'h0, 32'h00000010);
    add_row(op_bitrev, 32'h12345678, 32'h0, 32'h0, 32'h1e6a2c48);
    add_row(op_revb, 32'h12345678, 32'h0, 32'h0, 32'h78563412);
    add_row(op_seb, 32'h00000080, 32'h0, 32'h0, 32'hffffff80);
    add_row(op_seb, 32'habcdef7f, 32'h0, 32'h0, 32'h0000007f);
    add_row(op_seh, 32'h12348000, 32'h0, 32'h0, 32'hffff8000);
    add_row(alu_op_e'(5'd31), 32'hffffffff, 32'hffffffff, 32'h0, 32'h00000000);
  endfunction

  task automatic check_word(input int idx, input string sig, input alu_word_t got,
                            input alu_word_t exp, inout int errs);
    assert (got === exp)
      else begin
        $display("FAILED test %0d: %s = 0x%08h, expected 0x%08h", idx, sig, got, exp);
        errs++;
      end
  endtask

  task automatic finish_test(input int idx, input string name, input int errs);
    test_cnt++;
    if (errs == 0) begin
      pass_cnt++;
      $display("test %0d %s: ok", idx, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: %0d errors", idx, name, errs);
    end
  endtask

  task automatic drive_request(input alu_op_e op, input alu_word_t a, input alu_word_t b,
                               input alu_word_t c);
    @(posedge clk);
    req_valid <= 1'b1;
    req.op <= op;
    req.a <= a;
    req.b <= b;
    req.c <= c;
  endtask

  task automatic wait_result(output bit seen);
    seen = 1'b0;
    for (int i = 0; i < TIMEOUT_CYCLES && !seen; i++) begin
      @(negedge clk);
      seen = res_valid;
    end
  endtask

  // idle outputs after reset, then one request
  task automatic check_timing();
    int errs;
    int idx;
    errs = 0;
    idx = test_cnt + 1;
    repeat (3) begin
      @(negedge clk);
      check_word(idx, "res_valid", {31'b0, res_valid}, 32'h0, errs);
      check_word(idx, "res", res, 32'h0, errs);
    end
    drive_request(op_add, 32'h1, 32'h2, 32'h0);
    @(negedge clk);
    check_word(idx, "res_valid", {31'b0, res_valid}, 32'h0, errs);
    @(posedge clk);
    req_valid <= 1'b0;
    @(negedge clk);
    check_word(idx, "res_valid", {31'b0, res_valid}, 32'h1, errs);
    check_word(idx, "res", res, 32'h3, errs);
    @(negedge clk);
    check_word(idx, "res_valid", {31'b0, res_valid}, 32'h0, errs);
    check_word(idx, "res", res, 32'h3, errs);
    finish_test(idx, "reset and single request timing", errs);
  endtask

  task automatic run_table();
    int errs;
    int idx;
    bit seen;
    alu_op_e op;
    foreach (rows[i]) begin
      errs = 0;
      idx = test_cnt + 1;
      op = rows[i].op;
      drive_request(op, rows[i].a, rows[i].b, rows[i].c);
      @(posedge clk);
      req_valid <= 1'b0;
      wait_result(seen);
      if (!seen) begin
        $display("test %0d: no result within %0d cycles", idx, TIMEOUT_CYCLES);
        errs++;
      end else begin
        check_word(idx, "res", res, rows[i].expected, errs);
      end
      finish_test(idx, $sformatf("row %0d op %0d %s", i, op, op.name()), errs);
    end
  endtask

  task automatic collect_stream_result(input int idx, inout int errs);
    alu_word_t exp;
    if (res_valid) begin
      if (stream_exp.size() == 0) begin
        $display("test %0d: result 0x%08h arrived with nothing outstanding", idx, res);
        errs++;
      end else begin
        exp = stream_exp.pop_front();
        check_word(idx, "res", res, exp, errs);
      end
    end
  endtask

  task automatic run_streaming();
    int errs;
    int idx;
    alu_op_e op;
    alu_word_t a;
    alu_word_t b;
    alu_word_t exp;
    errs = 0;
    idx = test_cnt + 1;
    for (int i = 0; i < STREAM_LEN; i++) begin
      a = $urandom();
      b = $urandom();
      case ($urandom_range(0, 6))
        0, 1: begin op = op_add; exp = a + b; end
        2, 3: begin op = op_sub; exp = a - b; end
        4, 5: begin op = op_xor; exp = a ^ b; end
        default: begin op = alu_op_e'(5'($urandom_range(23, 31))); exp = '0; end
      endcase
      stream_exp.push_back(exp);
      drive_request(op, a, b, 32'h0);
      @(negedge clk);
      collect_stream_result(idx, errs);
    end
    @(posedge clk);
    req_valid <= 1'b0;
    for (int i = 0; i < TIMEOUT_CYCLES && stream_exp.size() != 0; i++) begin
      @(negedge clk);
      collect_stream_result(idx, errs);
    end
    if (stream_exp.size() != 0) begin
      $display("test %0d: %0d results never arrived", idx, stream_exp.size());
      errs++;
    end
    finish_test(idx, "back-to-back random stream", errs);
  endtask

  initial begin
    void'($urandom(78));
    rst_n = 1'b0;
    req_valid = 1'b0;
    req = '0;
    test_cnt = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    load_rows();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    check_timing();
    run_table();
    run_streaming();
    $display("%0d tests, %0d passed, %0d failed", test_cnt, pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
alu_data_pkg.sv
alu_op_pkg.sv
lead_counter.sv
alu_decoder.sv
alu_adder.sv
alu_shift_field.sv
alu_bitwise_unit.sv
alu_exec_stage.sv
tb_alu_exec_stage.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass message in the log
rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_alu_exec_stage -f list.f -o sim_alu \
  && ./obj_dir/sim_alu > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
